/* include/chol_consts.svh */
`ifndef CHOL_CONSTS_SVH
`define CHOL_CONSTS_SVH

// vector geometry
`define CHOL_BANDS       16
`define CHOL_MAX_EM      4

// word widths
`define CHOL_SAMPLE_W    8
`define CHOL_L_W         32
`define CHOL_ACC_W       64
`define CHOL_FRAC        8

// fixed unit latencies from go to done
`define CHOL_DIV_CYCLES  66
`define CHOL_SQRT_CYCLES 33

`endif

/* hw/chol_types_pkg.sv */
`include "chol_consts.svh"

package chol_types_pkg;

  // raw sample as read from the sample memory
  typedef logic signed [`CHOL_SAMPLE_W-1:0] sample_t;

  // L entries and Gram values with CHOL_FRAC fraction bits
  typedef logic signed [`CHOL_L_W-1:0] l_word_t;

  // full products, dividend and radicand
  typedef logic signed [`CHOL_ACC_W-1:0] acc_t;

  typedef logic [$clog2(`CHOL_BANDS)-1:0] band_t;
  typedef logic [$clog2(`CHOL_MAX_EM)-1:0] em_t;

  // packed lower triangle index
  typedef logic [$clog2(`CHOL_MAX_EM*(`CHOL_MAX_EM+1)/2)-1:0] tri_addr_t;

endpackage

/* hw/chol_ctrl_pkg.sv */
package chol_ctrl_pkg;

  // sequencer phases
  typedef enum logic [2:0] {
    IDLE,
    READ,   // stream samples, build Gram row
    SUM,    // L(i,k)*L(j,k) over k < j
    DIV,    // off-diagonal entry
    SQRT,   // diagonal entry
    DONE
  } phase_t;

  // accumulator operation
  typedef enum logic [1:0] {
    HOLD,
    CLEAR,
    ACC
  } mac_op_t;

endpackage

/* hw/dot_mac.sv */
`timescale 1ns/1ps

module dot_mac (
  input  logic                    clk,
  input  logic                    rst,
  input  chol_ctrl_pkg::mac_op_t  mac_op,
  input  chol_types_pkg::l_word_t mac_a,
  input  chol_types_pkg::l_word_t mac_b,
  output chol_types_pkg::acc_t    mac_acc
);

  chol_types_pkg::acc_t prod;

  assign prod = mac_a * mac_b;   // full width signed product

  always_ff @(posedge clk) begin
    if (rst) begin
      mac_acc <= '0;
    end else begin
      case (mac_op)
        chol_ctrl_pkg::CLEAR: mac_acc <= '0;
        chol_ctrl_pkg::ACC:   mac_acc <= mac_acc + prod;
        default:              mac_acc <= mac_acc;
      endcase
    end
  end

endmodule

/* hw/fx_divider.sv */
`timescale 1ns/1ps
`include "chol_consts.svh"

module fx_divider (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    div_go,
  input  chol_types_pkg::acc_t    dividend,
  input  chol_types_pkg::l_word_t divisor,
  output logic                    div_done,
  output chol_types_pkg::l_word_t quotient
);

  localparam int STEPS = `CHOL_ACC_W;   // one quotient bit per cycle

  logic                                  running;
  logic [$clog2(`CHOL_DIV_CYCLES)-1:0]   cnt;
  logic [`CHOL_ACC_W-1:0]                q;       // dividend out, quotient in
  logic [`CHOL_L_W:0]                    rem;
  logic [`CHOL_L_W:0]                    d_mag;
  logic [`CHOL_L_W:0]                    trial;
  logic                                  neg;
  logic                                  d_zero;

  assign trial = {rem[`CHOL_L_W-1:0], q[`CHOL_ACC_W-1]};

  always_ff @(posedge clk) begin
    if (rst) begin
      running  <= 1'b0;
      cnt      <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      if (div_go) begin
        running <= 1'b1;
        cnt     <= 1;
      end else if (running) begin
        cnt <= cnt + 1'b1;
        if (cnt == `CHOL_DIV_CYCLES - 1) begin
          running  <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // magnitude restoring division with the sign applied last
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (div_go) begin
      q      <= dividend[`CHOL_ACC_W-1] ? -dividend : dividend;
      d_mag  <= {1'b0, (divisor[`CHOL_L_W-1] ? -divisor : divisor)};
      rem    <= '0;
      neg    <= dividend[`CHOL_ACC_W-1] ^ divisor[`CHOL_L_W-1];
      d_zero <= (divisor == '0);
    end else if (running && (cnt <= STEPS)) begin
      if (trial >= d_mag) begin
        rem <= trial - d_mag;
        q   <= {q[`CHOL_ACC_W-2:0], 1'b1};
      end else begin
        rem <= trial;
        q   <= {q[`CHOL_ACC_W-2:0], 1'b0};
      end
    end else if (running) begin
      // truncates toward zero
      if (d_zero) begin
        quotient <= '0;
      end else begin
        quotient <= neg ? -q[`CHOL_L_W-1:0] : q[`CHOL_L_W-1:0];
      end
    end
  end

endmodule

/* hw/fx_sqrt.sv */
`timescale 1ns/1ps
`include "chol_consts.svh"

module fx_sqrt (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    sqrt_go,
  input  chol_types_pkg::acc_t    radicand,
  output logic                    sqrt_done,
  output chol_types_pkg::l_word_t root
);

  localparam int STEPS = `CHOL_SQRT_CYCLES - 1;   // two radicand bits each

  logic                                 running;
  logic [$clog2(`CHOL_SQRT_CYCLES)-1:0] cnt;
  logic [`CHOL_ACC_W-1:0]               x;
  logic [`CHOL_L_W-1:0]                 r;
  logic [`CHOL_L_W+2:0]                 rem;
  logic [`CHOL_L_W+2:0]                 rem_sh;
  logic [`CHOL_L_W+2:0]                 trial;

  // rem never exceeds 2r so its top bits stay clear
  assign rem_sh = {rem[`CHOL_L_W:0], x[`CHOL_ACC_W-1 -: 2]};
  assign trial  = {1'b0, r, 2'b01};
  assign root   = chol_types_pkg::l_word_t'(r);

  always_ff @(posedge clk) begin
    if (rst) begin
      running   <= 1'b0;
      cnt       <= '0;
      sqrt_done <= 1'b0;
    end else begin
      sqrt_done <= 1'b0;
      if (sqrt_go) begin
        running <= 1'b1;
        cnt     <= 1;
      end else if (running) begin
        cnt <= cnt + 1'b1;
        if (cnt == STEPS) begin
          running   <= 1'b0;
          sqrt_done <= 1'b1;   // last step lands with done
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sqrt_go) begin
      x   <= radicand;
      r   <= '0;
      rem <= '0;
    end else if (running) begin
      x <= {x[`CHOL_ACC_W-3:0], 2'b00};
      if (rem_sh >= trial) begin
        rem <= rem_sh - trial;
        r   <= {r[`CHOL_L_W-2:0], 1'b1};
      end else begin
        rem <= rem_sh;
        r   <= {r[`CHOL_L_W-2:0], 1'b0};
      end
    end
  end

endmodule

/* hw/tri_store.sv */
`timescale 1ns/1ps
`include "chol_consts.svh"

module tri_store (
  input  logic                    clk,
  input  logic                    rst,
  input  chol_types_pkg::em_t     a_row,
  input  chol_types_pkg::em_t     a_col,
  input  chol_types_pkg::em_t     b_row,
  input  chol_types_pkg::em_t     b_col,
  output chol_types_pkg::l_word_t a_data,
  output chol_types_pkg::l_word_t b_data,
  input  logic                    wr_en,
  input  chol_types_pkg::em_t     wr_row,
  input  chol_types_pkg::em_t     wr_col,
  input  chol_types_pkg::l_word_t wr_data,
  input  logic                    rd_valid,
  input  chol_types_pkg::em_t     rd_row,
  input  chol_types_pkg::em_t     rd_col,
  output chol_types_pkg::l_word_t rd_data,
  output logic                    rd_data_valid
);

  localparam int ENTRIES = `CHOL_MAX_EM * (`CHOL_MAX_EM + 1) / 2;

  chol_types_pkg::l_word_t mem [ENTRIES];   // kept across starts

  // row*(row+1)/2 + col
  function automatic chol_types_pkg::tri_addr_t tri_addr(input chol_types_pkg::em_t row,
                                                         input chol_types_pkg::em_t col);
    chol_types_pkg::tri_addr_t r;
    r = chol_types_pkg::tri_addr_t'(row);
    return chol_types_pkg::tri_addr_t'((r * (r + 1'b1)) >> 1) + chol_types_pkg::tri_addr_t'(col);
  endfunction

  assign a_data = mem[tri_addr(a_row, a_col)];
  assign b_data = mem[tri_addr(b_row, b_col)];

  always_ff @(posedge clk) begin
    if (wr_en) mem[tri_addr(wr_row, wr_col)] <= wr_data;
  end

  //////////////////////////////////////////////////////////////////////
  // readout port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      rd_data <= (rd_col > rd_row) ? '0 : mem[tri_addr(rd_row, rd_col)];   // upper half reads 0
    end
  end

  always_ff @(posedge clk) begin
    if (rst) rd_data_valid <= 1'b0;
    else     rd_data_valid <= rd_valid;
  end

endmodule

/* hw/chol_sequencer.sv */
`timescale 1ns/1ps
`include "chol_consts.svh"

module chol_sequencer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  chol_types_pkg::em_t     size,
  output logic                    addr_valid,
  output chol_types_pkg::band_t   u_band,
  output chol_types_pkg::em_t     u_col,
  output chol_types_pkg::band_t   vec_band,
  input  chol_types_pkg::sample_t u_data,
  input  chol_types_pkg::sample_t vec_data,
  input  logic                    data_valid,
  output logic                    busy,
  output logic                    done,
  output logic                    singular,
  output chol_ctrl_pkg::mac_op_t  mac_op,
  output chol_types_pkg::l_word_t mac_a,
  output chol_types_pkg::l_word_t mac_b,
  input  chol_types_pkg::acc_t    mac_acc,
  output logic                    div_go,
  output chol_types_pkg::acc_t    dividend,
  output chol_types_pkg::l_word_t divisor,
  input  logic                    div_done,
  input  chol_types_pkg::l_word_t quotient,
  output logic                    sqrt_go,
  output chol_types_pkg::acc_t    radicand,
  input  logic                    sqrt_done,
  input  chol_types_pkg::l_word_t root,
  output chol_types_pkg::em_t     a_row,
  output chol_types_pkg::em_t     a_col,
  output chol_types_pkg::em_t     b_row,
  output chol_types_pkg::em_t     b_col,
  input  chol_types_pkg::l_word_t a_data,
  input  chol_types_pkg::l_word_t b_data,
  output logic                    wr_en,
  output chol_types_pkg::em_t     wr_row,
  output chol_types_pkg::em_t     wr_col,
  output chol_types_pkg::l_word_t wr_data
);

  localparam chol_types_pkg::band_t LAST_BAND = chol_types_pkg::band_t'(`CHOL_BANDS - 1);

  chol_ctrl_pkg::phase_t   phase;
  chol_types_pkg::em_t     size_r;   // row i of this start
  chol_types_pkg::band_t   rx_band;
  chol_types_pkg::em_t     rx_col;
  logic                    g_wr;     // column sum ready on mac_acc
  chol_types_pkg::em_t     g_col;
  chol_types_pkg::l_word_t g_buf [`CHOL_MAX_EM];
  chol_types_pkg::acc_t    prev_sum;
  chol_types_pkg::em_t     j;
  chol_types_pkg::em_t     k;
  chol_types_pkg::acc_t    temp;
  chol_types_pkg::acc_t    temp_sh;
  logic                    at_eval;
  logic                    last_col;
  logic                    bad_diag;

  assign vec_band = u_band;
  assign busy     = (phase != chol_ctrl_pkg::IDLE);
  assign done     = (phase == chol_ctrl_pkg::DONE);

  //////////////////////////////////////////////////////////////////////
  // temp formation and unit launch
  //////////////////////////////////////////////////////////////////////

  // mac_acc holds S(j) once k reaches j
  assign temp     = (chol_types_pkg::acc_t'(g_buf[j]) <<< `CHOL_FRAC) - (mac_acc >>> `CHOL_FRAC);
  assign temp_sh  = temp <<< `CHOL_FRAC;
  assign at_eval  = (phase == chol_ctrl_pkg::SUM) && (k == j);
  assign last_col = (j == size_r);
  assign bad_diag = (temp <= 0);

  assign div_go   = at_eval && !last_col;
  assign sqrt_go  = at_eval && last_col && !bad_diag;
  assign dividend = temp_sh;
  assign radicand = temp_sh;
  assign divisor  = b_data;   // L(j,j) since b_col = k = j here

  // a is L(i,k), b is L(j,k)
  assign a_row = size_r;
  assign a_col = k;
  assign b_row = j;
  assign b_col = k;

  assign wr_row = size_r;
  assign wr_col = j;

  always_comb begin
    wr_en   = 1'b0;
    wr_data = quotient;
    case (phase)
      chol_ctrl_pkg::DIV:  wr_en = div_done;
      chol_ctrl_pkg::SQRT: begin
        wr_en   = sqrt_done;
        wr_data = root;
      end
      chol_ctrl_pkg::SUM: begin
        wr_en   = at_eval && last_col && bad_diag;   // singular diagonal
        wr_data = '0;
      end
      default: wr_en = 1'b0;
    endcase
  end

  always_comb begin
    mac_op = chol_ctrl_pkg::HOLD;
    mac_a  = a_data;
    mac_b  = b_data;
    case (phase)
      chol_ctrl_pkg::READ: begin
        // gaps before and after the stream clear the sum
        mac_op = data_valid ? chol_ctrl_pkg::ACC : chol_ctrl_pkg::CLEAR;
        mac_a  = chol_types_pkg::l_word_t'(u_data);
        mac_b  = chol_types_pkg::l_word_t'(vec_data);
      end
      chol_ctrl_pkg::SUM: mac_op = (k == j) ? chol_ctrl_pkg::CLEAR : chol_ctrl_pkg::ACC;
      default: mac_op = chol_ctrl_pkg::HOLD;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // phase machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= chol_ctrl_pkg::IDLE;
      addr_valid <= 1'b0;
      singular   <= 1'b0;
      size_r     <= '0;
      u_band     <= '0;
      u_col      <= '0;
      rx_band    <= '0;
      rx_col     <= '0;
      g_wr       <= 1'b0;
      j          <= '0;
      k          <= '0;
    end else begin
      g_wr <= data_valid && (rx_band == LAST_BAND);
      if (data_valid) begin
        if (rx_band == LAST_BAND) begin
          rx_band <= '0;
          rx_col  <= rx_col + 1'b1;
        end else begin
          rx_band <= rx_band + 1'b1;
        end
      end

      case (phase)
        chol_ctrl_pkg::IDLE: begin
          if (start) begin
            size_r     <= size;
            addr_valid <= 1'b1;
            u_band     <= '0;
            u_col      <= '0;
            rx_band    <= '0;
            rx_col     <= '0;
            singular   <= 1'b0;
            phase      <= chol_ctrl_pkg::READ;
          end
        end
        chol_ctrl_pkg::READ: begin
          if (addr_valid) begin   // band runs fastest
            if (u_band == LAST_BAND) begin
              u_band <= '0;
              if (u_col == size_r) begin
                addr_valid <= 1'b0;
              end else begin
                u_col <= u_col + 1'b1;
              end
            end else begin
              u_band <= u_band + 1'b1;
            end
          end
          if (g_wr && (g_col == size_r)) begin
            j     <= '0;
            k     <= '0;
            phase <= chol_ctrl_pkg::SUM;
          end
        end
        chol_ctrl_pkg::SUM: begin
          if (k != j) begin
            k <= k + 1'b1;
          end else if (!last_col) begin
            phase <= chol_ctrl_pkg::DIV;
          end else if (bad_diag) begin
            singular <= 1'b1;
            phase    <= chol_ctrl_pkg::DONE;
          end else begin
            phase <= chol_ctrl_pkg::SQRT;
          end
        end
        chol_ctrl_pkg::DIV: begin
          if (div_done) begin
            j     <= j + 1'b1;
            k     <= '0;
            phase <= chol_ctrl_pkg::SUM;
          end
        end
        chol_ctrl_pkg::SQRT: if (sqrt_done) phase <= chol_ctrl_pkg::DONE;
        chol_ctrl_pkg::DONE: phase <= chol_ctrl_pkg::IDLE;
        default: phase <= chol_ctrl_pkg::IDLE;
      endcase
    end
  end

  // g(j) is the difference of running sums
  always_ff @(posedge clk) begin
    g_col <= rx_col;
    if (phase == chol_ctrl_pkg::IDLE) begin
      prev_sum <= '0;
    end else if (g_wr) begin
      g_buf[g_col] <= chol_types_pkg::l_word_t'(mac_acc - prev_sum);
      prev_sum     <= mac_acc;
    end
  end

endmodule

/* hw/chol_update_top.sv */
`timescale 1ns/1ps

module chol_update_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  chol_types_pkg::em_t     size,
  output logic                    addr_valid,
  output chol_types_pkg::band_t   u_band,
  output chol_types_pkg::em_t     u_col,
  output chol_types_pkg::band_t   vec_band,
  input  chol_types_pkg::sample_t u_data,
  input  chol_types_pkg::sample_t vec_data,
  input  logic                    data_valid,
  output logic                    busy,
  output logic                    done,
  output logic                    singular,
  input  logic                    rd_valid,
  input  chol_types_pkg::em_t     rd_row,
  input  chol_types_pkg::em_t     rd_col,
  output chol_types_pkg::l_word_t rd_data,
  output logic                    rd_data_valid
);

  // accumulator
  chol_ctrl_pkg::mac_op_t  mac_op;
  chol_types_pkg::l_word_t mac_a;
  chol_types_pkg::l_word_t mac_b;
  chol_types_pkg::acc_t    mac_acc;

  // divider and square root
  logic                    div_go;
  chol_types_pkg::acc_t    dividend;
  chol_types_pkg::l_word_t divisor;
  logic                    div_done;
  chol_types_pkg::l_word_t quotient;
  logic                    sqrt_go;
  chol_types_pkg::acc_t    radicand;
  logic                    sqrt_done;
  chol_types_pkg::l_word_t root;

  // triangle store operand and write ports
  chol_types_pkg::em_t     a_row;
  chol_types_pkg::em_t     a_col;
  chol_types_pkg::em_t     b_row;
  chol_types_pkg::em_t     b_col;
  chol_types_pkg::l_word_t a_data;
  chol_types_pkg::l_word_t b_data;
  logic                    wr_en;
  chol_types_pkg::em_t     wr_row;
  chol_types_pkg::em_t     wr_col;
  chol_types_pkg::l_word_t wr_data;

  chol_sequencer seq_i (.*);
  dot_mac        mac_i (.*);
  fx_divider     div_i (.*);
  fx_sqrt        sqrt_i (.*);
  tri_store      store_i (.*);

endmodule

/* dv/chol_assert.sv */
`timescale 1ns/1ps

module chol_assert (
  input logic clk,
  input logic rst,
  input logic start,
  input logic busy,
  input logic done,
  input logic addr_valid,
  input logic rd_valid,
  input logic rd_data_valid
);

  int fail_count = 0;

  done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      $error("done held high for more than one cycle");
      fail_count++;
    end

  // idle start opens the stream on the next cycle
  start_accepted: assert property (@(posedge clk) disable iff (rst)
    (start && !busy) |=> (addr_valid && busy))
    else begin
      $error("start in idle did not open the address stream");
      fail_count++;
    end

  busy_start_ignored: assert property (@(posedge clk) disable iff (rst)
    $rose(addr_valid) |-> $past(start && !busy))
    else begin
      $error("address stream restarted without an idle start");
      fail_count++;
    end

  rd_follows: assert property (@(posedge clk) disable iff (rst) rd_valid |=> rd_data_valid)
    else begin
      $error("rd_data_valid missing one cycle after rd_valid");
      fail_count++;
    end

  rd_no_extra: assert property (@(posedge clk) disable iff (rst)
    rd_data_valid |-> $past(rd_valid))
    else begin
      $error("rd_data_valid without a readout request");
      fail_count++;
    end

endmodule

/* dv/chol_checker.sv */
`timescale 1ns/1ps
`include "chol_consts.svh"

module chol_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  chol_types_pkg::em_t     size,
  input  logic                    addr_valid,
  input  chol_types_pkg::band_t   u_band,
  input  chol_types_pkg::em_t     u_col,
  input  chol_types_pkg::band_t   vec_band,
  input  logic                    busy,
  input  logic                    done,
  input  logic                    singular,
  input  logic                    rd_valid,
  input  chol_types_pkg::em_t     rd_row,
  input  chol_types_pkg::em_t     rd_col,
  input  chol_types_pkg::l_word_t rd_data,
  input  logic                    rd_data_valid,
  input  chol_types_pkg::l_word_t exp_data,
  input  logic                    exp_singular,
  input  int                      test_id,
  input  logic                    test_end,
  input  logic                    summary,
  output int                      err_count
);

  int                      checks;
  int                      test_checks;
  int                      test_errs;
  int                      tests_run;
  int                      addr_idx;   // entries seen in this stream
  int                      exp_size;
  logic                    rst_q;
  logic                    started;
  logic                    done_q;
  logic                    rd_q;
  chol_types_pkg::l_word_t exp_q;
  chol_types_pkg::em_t     row_q;
  chol_types_pkg::em_t     col_q;

  initial begin
    err_count   = 0;
    checks      = 0;
    test_checks = 0;
    test_errs   = 0;
    tests_run   = 0;
    addr_idx    = 0;
    exp_size    = 0;
    rst_q       = 1'b0;
    started     = 1'b0;
    done_q      = 1'b0;
    rd_q        = 1'b0;
  end

  task automatic check(input logic signed [63:0] got, input logic signed [63:0] exp,
                       input string what);
    checks++;
    test_checks++;
    if (got !== exp) begin
      $display("FAIL t=%0t: %s got %0d expected %0d", $time, what, got, exp);
      err_count++;
      test_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // DUT outputs sampled on the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    rst_q <= rst;
    if (rst_q && !rst) begin   // first edge out of reset
      check(addr_valid, 0, "addr_valid after reset");
      check(busy, 0, "busy after reset");
      check(done, 0, "done after reset");
      check(singular, 0, "singular after reset");
      check(rd_data_valid, 0, "rd_data_valid after reset");
    end
    if (!rst) begin
      started <= start && !busy;
      if (start && !busy) begin
        exp_size <= size;
        addr_idx <= 0;
      end
      if (started) check(addr_valid, 1, "addr_valid the cycle after start");
      if (addr_valid) begin
        check(u_band, addr_idx % `CHOL_BANDS, "u_band");
        check(u_col, addr_idx / `CHOL_BANDS, "u_col");
        check(vec_band, addr_idx % `CHOL_BANDS, "vec_band");
        addr_idx <= addr_idx + 1;
      end
      if (done) begin
        check(addr_idx, (exp_size + 1) * `CHOL_BANDS, "address count");
        check(singular, exp_singular, "singular at done");
      end
      done_q <= done;
      if (done_q) check(busy, 0, "busy after done");

      // readout lags rd_valid by one cycle
      rd_q  <= rd_valid;
      exp_q <= exp_data;
      row_q <= rd_row;
      col_q <= rd_col;
      if (rd_data_valid || rd_q) check(rd_data_valid, rd_q, "rd_data_valid timing");
      if (rd_data_valid && rd_q) begin
        check(rd_data, exp_q, $sformatf("L(%0d,%0d)", row_q, col_q));
      end

      if (test_end) begin
        tests_run++;
        $display("test %0d finished: %0d checks, %0d errors", test_id, test_checks, test_errs);
        test_checks = 0;
        test_errs   = 0;
      end
      if (summary) begin
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, err_count);
      end
    end
  end

endmodule

/* dv/chol_tb.sv */
`timescale 1ns/1ps
`include "chol_consts.svh"

module chol_tb;

  logic                    clk;
  logic                    rst;
  logic                    start;
  chol_types_pkg::em_t     size;
  logic                    addr_valid;
  chol_types_pkg::band_t   u_band;
  chol_types_pkg::em_t     u_col;
  chol_types_pkg::band_t   vec_band;
  chol_types_pkg::sample_t u_data;
  chol_types_pkg::sample_t vec_data;
  logic                    data_valid;
  logic                    busy;
  logic                    done;
  logic                    singular;
  logic                    rd_valid;
  chol_types_pkg::em_t     rd_row;
  chol_types_pkg::em_t     rd_col;
  chol_types_pkg::l_word_t rd_data;
  logic                    rd_data_valid;

  // checker side
  chol_types_pkg::l_word_t exp_data;
  logic                    exp_singular;
  int                      test_id;
  logic                    test_end;
  logic                    summary;
  int                      err_count;

  chol_types_pkg::sample_t em_mem [`CHOL_MAX_EM][`CHOL_BANDS];
  chol_types_pkg::l_word_t ref_l [`CHOL_MAX_EM][`CHOL_MAX_EM];
  logic [15:0]             lfsr;
  int                      cur_size;   // column of the new vector
  logic                    pend_valid;
  chol_types_pkg::em_t     pend_col;
  chol_types_pkg::band_t   pend_band;
  chol_types_pkg::band_t   pend_vband;

  chol_update_top dut_i (.*);
  chol_checker    chk_i (.*);

  bind chol_update_top chol_assert assert_i (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // sample memory answers one cycle after each address
  always @(negedge clk) begin
    data_valid = pend_valid;
    u_data     = em_mem[pend_col][pend_band];
    vec_data   = em_mem[cur_size][pend_vband];
    pend_valid = rst ? 1'b0 : addr_valid;
    pend_col   = u_col;
    pend_band  = u_band;
    pend_vband = vec_band;
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_sample(output chol_types_pkg::sample_t v);
    int n;
    v = '0;
    for (n = 0; n < `CHOL_SAMPLE_W; n++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[`CHOL_SAMPLE_W-2:0], lfsr[0]};
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // expected row i of L from the rows below it in ref_l
  //////////////////////////////////////////////////////////////////////

  function automatic logic ref_update(input int i);
    longint g;
    longint s;
    longint temp;
    longint rad;
    longint root;
    longint t;
    int     j;
    int     k;
    int     b;
    int     n;
    logic   sing;
    sing = 1'b0;
    for (j = 0; j <= i; j++) begin
      g = 0;
      for (b = 0; b < `CHOL_BANDS; b++) g += longint'(em_mem[j][b]) * longint'(em_mem[i][b]);
      s = 0;
      for (k = 0; k < j; k++) s += longint'(ref_l[i][k]) * longint'(ref_l[j][k]);
      temp = (g <<< `CHOL_FRAC) - (s >>> `CHOL_FRAC);
      if (j < i) begin
        if (ref_l[j][j] == 0) ref_l[i][j] = '0;
        else ref_l[i][j] = chol_types_pkg::l_word_t'((temp <<< `CHOL_FRAC) / longint'(ref_l[j][j]));
      end else if (temp <= 0) begin
        ref_l[i][i] = '0;
        sing        = 1'b1;
      end else begin
        rad  = temp <<< `CHOL_FRAC;
        root = 0;
        for (n = 30; n >= 0; n--) begin   // floor root bit by bit
          t = root | (longint'(1) << n);
          if (t * t <= rad) root = t;
        end
        ref_l[i][i] = chol_types_pkg::l_word_t'(root);
      end
    end
    return sing;
  endfunction

  // worst case cycles for one start and its readout
  function automatic int start_budget(input int sz);
    int cyc;
    int j;
    cyc = 4 + (sz + 1) * `CHOL_BANDS;
    for (j = 0; j <= sz; j++) cyc += j + 2;
    cyc += sz * (`CHOL_DIV_CYCLES + 2) + `CHOL_SQRT_CYCLES + 2;
    cyc += (sz + 1) * `CHOL_MAX_EM + 8;
    return cyc;
  endfunction

  // start pulse with another size while the DUT is busy
  task automatic busy_start(input int sz);
    size  = chol_types_pkg::em_t'(sz ^ 1);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    size  = chol_types_pkg::em_t'(sz);
  endtask

  task automatic run_start(input int sz);
    cur_size     = sz;
    exp_singular = ref_update(sz);
    @(negedge clk);
    size  = chol_types_pkg::em_t'(sz);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (5) @(negedge clk);
    busy_start(sz);   // inside the address stream
    while (addr_valid) @(negedge clk);
    busy_start(sz);   // after the stream has ended
    while (!done) @(negedge clk);
  endtask

  task automatic read_rows(input int sz);
    int r;
    int c;
    for (r = 0; r <= sz; r++) begin
      for (c = 0; c < `CHOL_MAX_EM; c++) begin
        @(negedge clk);
        rd_valid = 1'b1;
        rd_row   = chol_types_pkg::em_t'(r);
        rd_col   = chol_types_pkg::em_t'(c);
        exp_data = (c > r) ? '0 : ref_l[r][c];
      end
    end
    @(negedge clk);
    rd_valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic end_test(input int id);
    @(negedge clk);
    test_id  = id;
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin : stimulus
    int sz;
    int e;
    int b;
    rst          = 1'b1;
    start        = 1'b0;
    size         = '0;
    u_data       = '0;
    vec_data     = '0;
    data_valid   = 1'b0;
    rd_valid     = 1'b0;
    rd_row       = '0;
    rd_col       = '0;
    exp_data     = '0;
    exp_singular = 1'b0;
    test_id      = 0;
    test_end     = 1'b0;
    summary      = 1'b0;
    cur_size     = 0;
    pend_valid   = 1'b0;
    pend_col     = '0;
    pend_band    = '0;
    pend_vband   = '0;
    lfsr         = 16'd9;
    for (e = 0; e < `CHOL_MAX_EM; e++) begin
      for (b = 0; b < `CHOL_MAX_EM; b++) ref_l[e][b] = '0;
      for (b = 0; b < `CHOL_BANDS; b++) draw_sample(em_mem[e][b]);
    end

    repeat (3) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    end_test(1);

    for (sz = 0; sz < `CHOL_MAX_EM; sz++) begin
      run_start(sz);
      read_rows(sz);
      end_test(sz + 2);
    end

    // zero vector 3 makes the last diagonal singular
    for (b = 0; b < `CHOL_BANDS; b++) em_mem[3][b] = '0;
    run_start(3);
    read_rows(3);
    end_test(6);

    @(negedge clk);
    summary = 1'b1;
    @(negedge clk);
    summary = 1'b0;
    @(negedge clk);
    if (err_count == 0 && dut_i.assert_i.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    limit = 20 + 2 * (start_budget(0) + start_budget(1) + start_budget(2)
                      + 2 * start_budget(3));
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", limit);
    $display("Test failures found");
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
hw/chol_types_pkg.sv
hw/chol_ctrl_pkg.sv
hw/dot_mac.sv
hw/fx_divider.sv
hw/fx_sqrt.sv
hw/tri_store.sv
hw/chol_sequencer.sv
hw/chol_update_top.sv
dv/chol_assert.sv
dv/chol_checker.sv
dv/chol_tb.sv
